//--- build.f
common/rv32_pkg.sv
common/core_ctrl_if.sv
hw/alu.sv
hw/register_file.sv
core/core_controller.sv
core/core_datapath.sv
core/rv32i_core.sv
dv/rv32i_core_chk.sv
dv/tb_rv32i_core.sv

//--- common/core_ctrl_if.sv
`timescale 1ns/1ns

interface core_ctrl_if;

    // instruction fields, decoded from IR in the datapath
    rv32_pkg::opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // register write strobes, each acts at the next rising clk
    logic ir_write;
    logic pc_write;
    logic pc_plus4_write;
    logic alu_last_write;
    logic mem_data_write;
    logic reg_write;

    // datapath selects
    rv32_pkg::alu_op_t alu_op;
    rv32_pkg::alu_src_a_t alu_src_a;
    rv32_pkg::alu_src_b_t alu_src_b;
    rv32_pkg::result_src_t result_src;
    rv32_pkg::addr_src_t addr_src;

    modport ctrl (
        input  opcode, funct3, funct7,
        output ir_write, pc_write, pc_plus4_write, alu_last_write, mem_data_write, reg_write,
        output alu_op, alu_src_a, alu_src_b, result_src, addr_src
    );

    modport dp (
        output opcode, funct3, funct7,
        input  ir_write, pc_write, pc_plus4_write, alu_last_write, mem_data_write, reg_write,
        input  alu_op, alu_src_a, alu_src_b, result_src, addr_src
    );

endinterface

//--- common/rv32_pkg.sv
package rv32_pkg;

    // data and address width of the core
    localparam int xlen = 32;

    // register index width, 32 architectural registers
    localparam int reg_addr_w = 5;

    // first instruction is fetched from word zero
    localparam logic [xlen-1:0] pc_start = '0;

    // major opcodes of the kept instruction groups, RV32I encodings
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_ITYPE = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_RTYPE = 7'b0110011
    } opcode_t;

    // operations the ALU can perform
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // multicycle controller states
    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_MEMADR,
        S_MEMREAD,
        S_MEMWB,
        S_MEMWRITE,
        S_EXECUTE,
        S_ALUWB
    } core_state_t;

    // alu operand a source
    typedef enum logic {SRC_A_PC, SRC_A_REG} alu_src_a_t;

    // alu operand b source
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} alu_src_b_t;

    // register file write-back source
    typedef enum logic {RESULT_ALU_LAST, RESULT_MEM_DATA} result_src_t;

    // memory address source, instruction fetch or data access
    typedef enum logic {ADDR_PC, ADDR_ALU_LAST} addr_src_t;

endpackage

//--- core/core_controller.sv
`timescale 1ns/1ns

module core_controller (
    input  logic                      clk,
    input  logic                      rst,
    core_ctrl_if.ctrl                 bus,
    output logic                      mem_wr_ena,
    output logic                      instruction_done,
    output logic [rv32_pkg::xlen-1:0] instructions_completed
);

    rv32_pkg::core_state_t state;
    rv32_pkg::core_state_t state_next;

    // funct7 bit 5 (instruction bit 30) picks SUB and SRA
    logic alt_op;

    assign alt_op = bus.funct7[5];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rv32_pkg::S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    // next state
    always_comb begin
        state_next = rv32_pkg::S_FETCH;
        case (state)
            rv32_pkg::S_FETCH: state_next = rv32_pkg::S_DECODE;
            rv32_pkg::S_DECODE: begin
                case (bus.opcode)
                    rv32_pkg::OP_LOAD, rv32_pkg::OP_STORE: state_next = rv32_pkg::S_MEMADR;
                    rv32_pkg::OP_RTYPE, rv32_pkg::OP_ITYPE: state_next = rv32_pkg::S_EXECUTE;
                    // anything else retires nothing
                    default: state_next = rv32_pkg::S_FETCH;
                endcase
            end
            rv32_pkg::S_MEMADR: begin
                if (bus.opcode == rv32_pkg::OP_LOAD) begin
                    state_next = rv32_pkg::S_MEMREAD;
                end else begin
                    state_next = rv32_pkg::S_MEMWRITE;
                end
            end
            rv32_pkg::S_MEMREAD: state_next = rv32_pkg::S_MEMWB;
            rv32_pkg::S_EXECUTE: state_next = rv32_pkg::S_ALUWB;
            // MEMWB, MEMWRITE and ALUWB all end the instruction
            default: state_next = rv32_pkg::S_FETCH;
        endcase
    end

    // strobes and selects per state
    always_comb begin
        // all strobes low unless the state needs them
        bus.ir_write = 1'b0;
        bus.pc_write = 1'b0;
        bus.pc_plus4_write = 1'b0;
        bus.alu_last_write = 1'b0;
        bus.mem_data_write = 1'b0;
        bus.reg_write = 1'b0;
        bus.alu_op = rv32_pkg::ALU_ADD;
        bus.alu_src_a = rv32_pkg::SRC_A_REG;
        bus.alu_src_b = rv32_pkg::SRC_B_IMM;
        bus.result_src = rv32_pkg::RESULT_ALU_LAST;
        bus.addr_src = rv32_pkg::ADDR_PC;
        mem_wr_ena = 1'b0;
        instruction_done = 1'b0;
        case (state)
            rv32_pkg::S_FETCH: begin
                // read the instruction at PC and form PC+4 on the ALU
                bus.addr_src = rv32_pkg::ADDR_PC;
                bus.ir_write = 1'b1;
                bus.alu_op = rv32_pkg::ALU_ADD;
                bus.alu_src_a = rv32_pkg::SRC_A_PC;
                bus.alu_src_b = rv32_pkg::SRC_B_FOUR;
                bus.pc_plus4_write = 1'b1;
            end
            rv32_pkg::S_DECODE: begin
                // unsupported opcode, just step over it
                case (bus.opcode)
                    rv32_pkg::OP_LOAD, rv32_pkg::OP_STORE,
                    rv32_pkg::OP_RTYPE, rv32_pkg::OP_ITYPE: bus.pc_write = 1'b0;
                    default: bus.pc_write = 1'b1;
                endcase
            end
            rv32_pkg::S_MEMADR: begin
                // effective address is rs1 plus offset
                bus.alu_op = rv32_pkg::ALU_ADD;
                bus.alu_src_a = rv32_pkg::SRC_A_REG;
                bus.alu_src_b = rv32_pkg::SRC_B_IMM;
                bus.alu_last_write = 1'b1;
            end
            rv32_pkg::S_MEMREAD: begin
                bus.addr_src = rv32_pkg::ADDR_ALU_LAST;
                bus.mem_data_write = 1'b1;
            end
            rv32_pkg::S_MEMWB: begin
                bus.result_src = rv32_pkg::RESULT_MEM_DATA;
                bus.reg_write = 1'b1;
                bus.pc_write = 1'b1;
                instruction_done = 1'b1;
            end
            rv32_pkg::S_MEMWRITE: begin
                bus.addr_src = rv32_pkg::ADDR_ALU_LAST;
                mem_wr_ena = 1'b1;
                bus.pc_write = 1'b1;
                instruction_done = 1'b1;
            end
            rv32_pkg::S_EXECUTE: begin
                bus.alu_src_a = rv32_pkg::SRC_A_REG;
                if (bus.opcode == rv32_pkg::OP_ITYPE) begin
                    bus.alu_src_b = rv32_pkg::SRC_B_IMM;
                end else begin
                    bus.alu_src_b = rv32_pkg::SRC_B_REG;
                end
                bus.alu_last_write = 1'b1;
                case (bus.funct3)
                    // only the register form has SUB, ADDI ignores bit 30
                    3'b000: begin
                        if ((bus.opcode == rv32_pkg::OP_RTYPE) && alt_op) begin
                            bus.alu_op = rv32_pkg::ALU_SUB;
                        end else begin
                            bus.alu_op = rv32_pkg::ALU_ADD;
                        end
                    end
                    3'b001: bus.alu_op = rv32_pkg::ALU_SLL;
                    3'b010: bus.alu_op = rv32_pkg::ALU_SLT;
                    3'b011: bus.alu_op = rv32_pkg::ALU_SLTU;
                    3'b100: bus.alu_op = rv32_pkg::ALU_XOR;
                    // SRL or SRA, same for SRLI and SRAI
                    3'b101: begin
                        if (alt_op) begin
                            bus.alu_op = rv32_pkg::ALU_SRA;
                        end else begin
                            bus.alu_op = rv32_pkg::ALU_SRL;
                        end
                    end
                    3'b110: bus.alu_op = rv32_pkg::ALU_OR;
                    default: bus.alu_op = rv32_pkg::ALU_AND;
                endcase
            end
            rv32_pkg::S_ALUWB: begin
                bus.result_src = rv32_pkg::RESULT_ALU_LAST;
                bus.reg_write = 1'b1;
                bus.pc_write = 1'b1;
                instruction_done = 1'b1;
            end
            default: begin
                bus.addr_src = rv32_pkg::ADDR_PC;
            end
        endcase
    end

    // retired instruction counter, bumps at the edge ending the last cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            instructions_completed <= '0;
        end else if (instruction_done) begin
            instructions_completed <= instructions_completed + 1'b1;
        end
    end

endmodule

//--- core/core_datapath.sv
`timescale 1ns/1ns

module core_datapath (
    input  logic                      clk,
    input  logic                      rst,
    core_ctrl_if.dp                   bus,
    input  logic [rv32_pkg::xlen-1:0] mem_rd_data,
    output logic [rv32_pkg::xlen-1:0] mem_addr,
    output logic [rv32_pkg::xlen-1:0] mem_wr_data,
    output logic [rv32_pkg::xlen-1:0] pc
);

    // architectural and non-architectural registers
    logic [rv32_pkg::xlen-1:0] ir;
    logic [rv32_pkg::xlen-1:0] pc_plus4;
    logic [rv32_pkg::xlen-1:0] reg_a;
    logic [rv32_pkg::xlen-1:0] reg_b;
    logic [rv32_pkg::xlen-1:0] alu_last;
    logic [rv32_pkg::xlen-1:0] mem_data;

    // decoded fields
    rv32_pkg::opcode_t opcode;
    logic [rv32_pkg::reg_addr_w-1:0] rd;
    logic [rv32_pkg::reg_addr_w-1:0] rs1;
    logic [rv32_pkg::reg_addr_w-1:0] rs2;
    logic [rv32_pkg::xlen-1:0] imm;

    logic [rv32_pkg::xlen-1:0] rf_data0;
    logic [rv32_pkg::xlen-1:0] rf_data1;
    logic [rv32_pkg::xlen-1:0] src_a;
    logic [rv32_pkg::xlen-1:0] src_b;
    logic [rv32_pkg::xlen-1:0] alu_result;
    logic [rv32_pkg::xlen-1:0] result;

    assign opcode = rv32_pkg::opcode_t'(ir[6:0]);
    assign rd = ir[11:7];
    assign rs1 = ir[19:15];
    assign rs2 = ir[24:20];

    // fields to the controller
    assign bus.opcode = opcode;
    assign bus.funct3 = ir[14:12];
    assign bus.funct7 = ir[31:25];

    // S-form for stores, I-form for everything else
    always_comb begin
        if (opcode == rv32_pkg::OP_STORE) begin
            imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
        end else begin
            imm = {{20{ir[31]}}, ir[31:20]};
        end
    end

    // PC is the only datapath register with a reset value
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= rv32_pkg::pc_start;
        end else if (bus.pc_write) begin
            pc <= pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.ir_write) begin
            ir <= mem_rd_data;
        end
        if (bus.pc_plus4_write) begin
            pc_plus4 <= alu_result;
        end
        if (bus.alu_last_write) begin
            alu_last <= alu_result;
        end
        if (bus.mem_data_write) begin
            mem_data <= mem_rd_data;
        end
        // operand registers follow the register file every cycle
        reg_a <= rf_data0;
        reg_b <= rf_data1;
    end

    // operand muxes
    always_comb begin
        if (bus.alu_src_a == rv32_pkg::SRC_A_PC) begin
            src_a = pc;
        end else begin
            src_a = reg_a;
        end
        case (bus.alu_src_b)
            rv32_pkg::SRC_B_REG: src_b = reg_b;
            rv32_pkg::SRC_B_IMM: src_b = imm;
            default: src_b = 32'd4;
        endcase
    end

    // write-back and address muxes
    assign result = (bus.result_src == rv32_pkg::RESULT_MEM_DATA) ? mem_data : alu_last;
    assign mem_addr = (bus.addr_src == rv32_pkg::ADDR_ALU_LAST) ? alu_last : pc;

    // stores always take rs2 data
    assign mem_wr_data = reg_b;

    alu u_alu (
        .a(src_a),
        .b(src_b),
        .op(bus.alu_op),
        .result(alu_result)
    );

    register_file u_register_file (
        .clk(clk),
        .rst(rst),
        .wr_ena(bus.reg_write),
        .wr_addr(rd),
        .wr_data(result),
        .rd_addr0(rs1),
        .rd_addr1(rs2),
        .rd_data0(rf_data0),
        .rd_data1(rf_data1)
    );

endmodule

//--- core/rv32i_core.sv
`timescale 1ns/1ns

module rv32i_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [rv32_pkg::xlen-1:0] mem_rd_data,
    output logic [rv32_pkg::xlen-1:0] mem_addr,
    output logic [rv32_pkg::xlen-1:0] mem_wr_data,
    output logic                      mem_wr_ena,
    output logic [rv32_pkg::xlen-1:0] pc,
    output logic [rv32_pkg::xlen-1:0] instructions_completed,
    output logic                      instruction_done
);

    // controller to datapath link
    core_ctrl_if bus ();

    // FSM, decode and retire bookkeeping
    core_controller u_core_controller (
        .clk(clk),
        .rst(rst),
        .bus(bus.ctrl),
        .mem_wr_ena(mem_wr_ena),
        .instruction_done(instruction_done),
        .instructions_completed(instructions_completed)
    );

    // registers, ALU and register file
    core_datapath u_core_datapath (
        .clk(clk),
        .rst(rst),
        .bus(bus.dp),
        .mem_rd_data(mem_rd_data),
        .mem_addr(mem_addr),
        .mem_wr_data(mem_wr_data),
        .pc(pc)
    );

endmodule

//--- dv/rv32i_core_chk.sv
`timescale 1ns/1ns

module rv32i_core_chk (
    input logic        clk,
    input logic        rst,
    input logic [31:0] mem_addr,
    input logic        mem_wr_ena,
    input logic        instruction_done,
    input logic [31:0] instructions_completed
);

    // number of failed assertions, read by the testbench at the end of the run
    int assert_fails = 0;

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (rst)
        instruction_done |=> !instruction_done)
        else begin
            assert_fails++;
            $error("instruction_done stayed high for two cycles");
        end

    // a store takes exactly one cycle
    store_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_wr_ena |=> !mem_wr_ena)
        else begin
            assert_fails++;
            $error("mem_wr_ena stayed high for two cycles");
        end

    // word stores only
    store_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_wr_ena |-> (mem_addr[1:0] == 2'b00))
        else begin
            assert_fails++;
            $error("store address 0x%08h is not word aligned", mem_addr);
        end

    // retired counter steps once per done
    count_step: assert property (@(posedge clk) disable iff (rst)
        instruction_done |=> (instructions_completed == $past(instructions_completed) + 32'd1))
        else begin
            assert_fails++;
            $error("instructions_completed did not step after a done pulse");
        end

    // and holds otherwise
    count_hold: assert property (@(posedge clk) disable iff (rst)
        !instruction_done |=> $stable(instructions_completed))
        else begin
            assert_fails++;
            $error("instructions_completed changed without a done pulse");
        end

endmodule

bind rv32i_core rv32i_core_chk u_rv32i_core_chk (
    .clk(clk),
    .rst(rst),
    .mem_addr(mem_addr),
    .mem_wr_ena(mem_wr_ena),
    .instruction_done(instruction_done),
    .instructions_completed(instructions_completed)
);

//--- dv/tb_rv32i_core.sv
`timescale 1ns/1ns

module tb_rv32i_core;

    // RV32I encodings used by the program builder
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_imm = 7'b0010011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_reg = 7'b0110011;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [6:0] f7_alt = 7'b0100000;
    localparam logic [31:0] reset_pc = 32'h0;
    // preloaded data words start at byte 0x600
    localparam int load_word = 384;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [31:0] mem_rd_data;
    logic [31:0] mem_addr;
    logic [31:0] mem_wr_data;
    logic mem_wr_ena;
    logic [31:0] pc;
    logic [31:0] instructions_completed;
    logic instruction_done;

    integer seed = 32'h84fa4f80;

    // DUT memory and the architectural model
    logic [31:0] mem [1024];
    logic [31:0] mem_m [1024];
    logic [31:0] rf_m [32];
    logic [31:0] prog [$];
    // predicted stores and cycles per instruction in program order
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int exp_cycles [$];
    int error_count = 0;
    int done_count = 0;
    int cycle_count = 0;
    // next result slot as an offset from x2
    logic [11:0] slot = '0;

    always #4 clk = ~clk;

    rv32i_core UUT (
        .clk(clk),
        .rst(rst),
        .mem_rd_data(mem_rd_data),
        .mem_addr(mem_addr),
        .mem_wr_data(mem_wr_data),
        .mem_wr_ena(mem_wr_ena),
        .pc(pc),
        .instructions_completed(instructions_completed),
        .instruction_done(instruction_done)
    );

    // combinational read and a write on the rising edge
    assign mem_rd_data = mem[mem_addr[11:2]];

    always @(posedge clk) begin
        if (mem_wr_ena) begin
            mem[mem_addr[11:2]] <= mem_wr_data;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Error %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // ISA result of an ALU operation where alt is instruction bit 30
    function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic [31:0] r;
        sa = a;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = sa >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // one instruction on the model registers and memory
    function automatic void step_model(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] addr;
        logic [31:0] res;
        a = rf_m[ins[19:15]];
        b = rf_m[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        res = '0;
        case (ins[6:0])
            opc_reg: begin
                res = alu_expect(ins[14:12], ins[30], a, b);
                exp_cycles.push_back(4);
            end
            // only SRAI uses bit 30 among the immediate forms
            opc_imm: begin
                res = alu_expect(ins[14:12], ins[30] && (ins[14:12] == 3'd5), a, imm_i);
                exp_cycles.push_back(4);
            end
            opc_load: begin
                addr = a + imm_i;
                res = mem_m[addr[11:2]];
                exp_cycles.push_back(5);
            end
            default: begin
                addr = a + imm_s;
                mem_m[addr[11:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
                exp_cycles.push_back(4);
            end
        endcase
        // x0 never changes
        if ((ins[6:0] != opc_store) && (ins[11:7] != 5'd0)) begin
            rf_m[ins[11:7]] = res;
        end
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, f3_word, imm[4:0], opc_store};
    endfunction

    // appends to the program and keeps the model in step
    task automatic emit(input logic [31:0] ins);
        prog.push_back(ins);
        step_model(ins);
    endtask

    task automatic store_result(input logic [4:0] rs);
        emit(store_word(slot, rs, 5'd2));
        slot = slot + 12'd4;
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [3:0] r_ops [10];
        logic [3:0] i_ops [9];
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        // funct3 in the low bits and bit 3 set for SUB, SRA and SRAI
        r_ops = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
        i_ops = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hd};
        // x1 points at the loaded data and x2 at the result area
        emit(itype_word(12'h600, 5'd0, 3'd0, 5'd1, opc_imm));
        emit(itype_word(12'h780, 5'd0, 3'd0, 5'd2, opc_imm));
        for (int i = 0; i < 8; i++) begin
            emit(itype_word(12'(4 * i), 5'd1, f3_word, 5'(3 + i), opc_load));
        end
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 10; k++) begin
                r = $random(seed);
                // first round pairs negative x3 with positive x4
                rs1 = (round == 0) ? 5'd3 : 5'd3 + r[2:0];
                rs2 = (round == 0) ? 5'd4 : 5'd3 + r[5:3];
                emit(rtype_word(r_ops[k][3] ? f7_alt : 7'd0, rs2, rs1, r_ops[k][2:0], 5'd11));
                store_result(5'd11);
            end
        end
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 9; k++) begin
                r = $random(seed);
                rs1 = (round == 0) ? 5'd3 : 5'd3 + r[2:0];
                imm = r[31:20];
                if (round == 0) begin
                    imm[11] = 1'b1;
                end
                // shifts carry the amount in imm[4:0]
                if (i_ops[k][1:0] == 2'b01) begin
                    imm = {i_ops[k][3] ? f7_alt : 7'd0, r[24:20]};
                end
                emit(itype_word(imm, rs1, i_ops[k][2:0], 5'd12, opc_imm));
                store_result(5'd12);
            end
        end
        // negative then positive offset with each word loaded back and stored again
        emit(store_word(12'hf00, 5'd5, 5'd2));
        emit(itype_word(12'hf00, 5'd2, f3_word, 5'd13, opc_load));
        store_result(5'd13);
        emit(store_word(12'h400, 5'd6, 5'd2));
        emit(itype_word(12'h400, 5'd2, f3_word, 5'd14, opc_load));
        store_result(5'd14);
        // writes aimed at x0 are dropped
        emit(itype_word(12'h123, 5'd3, 3'd0, 5'd0, opc_imm));
        store_result(5'd0);
        emit(itype_word(12'h000, 5'd1, f3_word, 5'd0, opc_load));
        store_result(5'd0);
    endtask

    task automatic check_reset_state();
        compare_value("pc", pc, reset_pc);
        compare_value("instructions_completed", instructions_completed, 32'd0);
        compare_value("mem_wr_ena", mem_wr_ena, 1'b0);
        compare_value("instruction_done", instruction_done, 1'b0);
    endtask

    // store and retire checks against the model
    always @(posedge clk) begin
        if (!rst) begin
            cycle_count++;
            if (mem_wr_ena) begin
                if (exp_addr.size() == 0) begin
                    error_count++;
                    $display("a store happened that the model does not predict");
                end else begin
                    compare_value("mem_addr", mem_addr, exp_addr.pop_front());
                    compare_value("mem_wr_data", mem_wr_data, exp_data.pop_front());
                end
            end
            if (instruction_done) begin
                compare_value("instructions_completed", instructions_completed, done_count);
                if (exp_cycles.size() == 0) begin
                    error_count++;
                    $display("instruction_done pulsed after the whole program retired");
                end else begin
                    compare_value("done_interval", cycle_count, exp_cycles.pop_front());
                end
                cycle_count = 0;
                done_count++;
            end
        end
    end

    initial begin
        logic [31:0] word;
        int limit;
        int waited;
        int total;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = '0;
            mem_m[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            rf_m[i] = '0;
        end
        // data words with the first negative and the second positive
        for (int i = 0; i < 8; i++) begin
            word = $random(seed);
            if (i == 0) begin
                word[31] = 1'b1;
            end
            if (i == 1) begin
                word[31] = 1'b0;
            end
            mem[load_word + i] = word;
            mem_m[load_word + i] = word;
        end
        build_program();
        foreach (prog[i]) begin
            mem[i] = prog[i];
        end
        // reset held over two rising edges
        @(negedge clk);
        check_reset_state();
        @(negedge clk);
        check_reset_state();
        rst = 1'b0;
        // one cycle after release nothing has retired yet
        @(negedge clk);
        check_reset_state();
        limit = 6 * prog.size() + 100;
        waited = 0;
        while ((done_count < prog.size()) && (waited < limit)) begin
            @(negedge clk);
            waited++;
        end
        if (done_count < prog.size()) begin
            error_count++;
            $display("timeout, %0d of %0d instructions retired", done_count, prog.size());
        end else begin
            compare_value("instructions_completed", instructions_completed, prog.size());
            compare_value("pc", pc, reset_pc + 4 * prog.size());
            if (exp_addr.size() != 0) begin
                error_count++;
                $display("%0d predicted stores never happened", exp_addr.size());
            end
        end
        total = error_count + UUT.u_rv32i_core_chk.assert_fails;
        $display("errors: %0d", total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- hw/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [rv32_pkg::xlen-1:0] a,
    input  logic [rv32_pkg::xlen-1:0] b,
    input  rv32_pkg::alu_op_t         op,
    output logic [rv32_pkg::xlen-1:0] result
);

    // shift amount is the low five bits of b
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv32_pkg::ALU_ADD: result = a + b;
            rv32_pkg::ALU_SUB: result = a - b;
            rv32_pkg::ALU_SLL: result = a << shamt;
            // signed compare, result is 1 or 0
            rv32_pkg::ALU_SLT: begin
                result = {{(rv32_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
            // unsigned compare
            rv32_pkg::ALU_SLTU: begin
                result = {{(rv32_pkg::xlen-1){1'b0}}, a < b};
            end
            rv32_pkg::ALU_XOR: result = a ^ b;
            rv32_pkg::ALU_SRL: result = a >> shamt;
            // arithmetic shift keeps the sign bit
            rv32_pkg::ALU_SRA: result = $signed(a) >>> shamt;
            rv32_pkg::ALU_OR: result = a | b;
            rv32_pkg::ALU_AND: result = a & b;
            default: result = '0;
        endcase
    end

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wr_ena,
    input  logic [rv32_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [rv32_pkg::xlen-1:0]       wr_data,
    input  logic [rv32_pkg::reg_addr_w-1:0] rd_addr0,
    input  logic [rv32_pkg::reg_addr_w-1:0] rd_addr1,
    output logic [rv32_pkg::xlen-1:0]       rd_data0,
    output logic [rv32_pkg::xlen-1:0]       rd_data1
);

    logic [rv32_pkg::xlen-1:0] regs [2**rv32_pkg::reg_addr_w];

    // synchronous write, x0 is never written so it stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**rv32_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ena && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // asynchronous reads
    assign rd_data0 = regs[rd_addr0];
    assign rd_data1 = regs[rd_addr1];

endmodule
